// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := ioCmdTb
FILELIST := sources.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) ioCmd_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(BUILD) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: ioCmdDecode.sv
// Minor opcode decode, byte lane mask and core handshake steering
`timescale 1ns/1ps
`default_nettype none

`include "ioCmd_params.svh"

module ioCmdDecode (
    input  var ioCmdPkg::cpuCmdT   cmd,
    input  wire                    cmdAck,
    output logic                   cmdReq,
    input  wire                    queueReq,
    input  wire                    writebackReq,
    input  wire                    respPending,
    output ioCmdPkg::cmdClassT     cmdClass,
    output logic [`PORT_BYTES-1:0] laneMask,
    output logic                   storeGo,
    output logic                   queueGo,
    output logic                   loadGo
);

    // Store wins over the atomic bit
    always_comb begin
        if (cmd.minorOp[2]) begin
            cmdClass = ioCmdPkg::STORE;
        end else if (cmd.minorOp[3]) begin
            cmdClass = ioCmdPkg::ATOMIC_LOAD;
        end else begin
            cmdClass = ioCmdPkg::LOAD;
        end
    end

    // Byte sizes pick one lane, wider sizes an aligned lane pair
    always_comb begin
        if (cmd.minorOp[1:0] == 2'd0) begin
            laneMask = `PORT_BYTES'(1) << cmd.addrOffset[1:0];
        end else begin
            laneMask = `PORT_BYTES'(3) << {cmd.addrOffset[1], 1'b0};
        end
    end

    // Stale loads must not race a register response for the writeback port
    always_comb begin
        case (cmdClass)
            ioCmdPkg::STORE,
            ioCmdPkg::ATOMIC_LOAD: cmdReq = queueReq;
            ioCmdPkg::LOAD:        cmdReq = writebackReq && !respPending;
            default:               cmdReq = 1'b0;
        endcase
    end

    // One steered ACK per command class
    assign storeGo = cmdAck && (cmdClass == ioCmdPkg::STORE);
    assign queueGo = cmdAck && (cmdClass == ioCmdPkg::ATOMIC_LOAD);
    assign loadGo  = cmdAck && (cmdClass == ioCmdPkg::LOAD) && !respPending;

endmodule

`default_nettype wire

// File: ioCmdExecute.sv
// Store shadow word, byte lane merge and the port command queue
`timescale 1ns/1ps
`default_nettype none

`include "ioCmd_params.svh"

module ioCmdExecute (
    input  wire                      sys_clk,
    input  wire                      rstN,
    input  var ioCmdPkg::cpuCmdT     cmd,
    input  var ioCmdPkg::cmdClassT   cmdClass,
    input  wire  [`PORT_BYTES-1:0]   laneMask,
    input  wire                      queueGo,
    output logic                     queueReq,
    output ioCmdPkg::portCmdT        portCmd,
    output logic                     portCmdAck,
    input  wire                      portCmdReq
);

    logic [`PORT_WIDTH-1:0] shadowWord;
    logic [`PORT_WIDTH-1:0] storeLanes;
    logic [`PORT_WIDTH-1:0] mergedWord;
    ioCmdPkg::portCmdT      queueIn;
    logic                   isStore;

    assign isStore = (cmdClass == ioCmdPkg::STORE);

    // Spread the store data so every lane holds the right bytes
    always_comb begin
        if (cmd.minorOp[1:0] == 2'd0) begin
            storeLanes = {`PORT_BYTES{cmd.data[7:0]}};
        end else begin
            storeLanes = {(`PORT_BYTES / 2){cmd.data[15:0]}};
        end
    end

    always_comb begin
        mergedWord = shadowWord;
        for (int i = 0; i < `PORT_BYTES; i++) begin
            if (laneMask[i]) begin
                mergedWord[i*8 +: 8] = storeLanes[i*8 +: 8];
            end
        end
    end

    // Atomic loads carry the shadow word as it stands
    always_comb begin
        queueIn.responseRequested = !isStore;
        queueIn.destReg           = cmd.destReg;
        queueIn.data              = isStore ? mergedWord : shadowWord;
    end

    // Shadow follows a store on the same edge it is queued
    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            shadowWord <= '0;
        end else if (queueGo && queueReq && isStore) begin
            shadowWord <= mergedWord;
        end
    end

    ioCmdFifo #(
        .payloadT(ioCmdPkg::portCmdT)
    ) cmdQueue (
        .sys_clk(sys_clk),
        .rstN   (rstN),
        .inAck  (queueGo),
        .inReq  (queueReq),
        .inData (queueIn),
        .outAck (portCmdAck),
        .outReq (portCmdReq),
        .outData(portCmd)
    );

endmodule

`default_nettype wire

// File: ioCmdFifo.sv
// Single-clock FIFO with ACK/REQ handshakes, typed by its payload
`timescale 1ns/1ps
`default_nettype none

`include "ioCmd_params.svh"

module ioCmdFifo #(
    parameter type payloadT = logic
) (
    input  wire         sys_clk,
    input  wire         rstN,
    input  wire         inAck,
    output logic        inReq,
    input  var payloadT inData,
    output logic        outAck,
    input  wire         outReq,
    output payloadT     outData
);

    localparam int PTR_W = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    payloadT            mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W-1:0]   rdPtr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    assign inReq   = (count != CNT_W'(`QUEUE_DEPTH));
    assign outAck  = (count != '0);
    assign push    = inAck && inReq;
    assign pop     = outAck && outReq;
    assign outData = mem[rdPtr];

    // Storage is written only on a transfer
    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: ioCmdPkg.sv
// Command class enum and the command, port and writeback structs
`default_nettype none

`include "ioCmd_params.svh"

package ioCmdPkg;

    // Class decoded from the minor opcode
    typedef enum logic [1:0] {
        LOAD,
        ATOMIC_LOAD,
        STORE
    } cmdClassT;

    // Command from the core
    // minorOp[2] store, minorOp[3] atomic load, minorOp[1:0] size
    typedef struct packed {
        logic [3:0]             minorOp;
        logic [3:0]             destReg;
        logic [`DATA_WIDTH-1:0] addrOffset;
        logic [`DATA_WIDTH-1:0] data;
    } cpuCmdT;

    // Command sent out on the port
    typedef struct packed {
        logic                   responseRequested;
        logic [3:0]             destReg;
        logic [`PORT_WIDTH-1:0] data;
    } portCmdT;

    // Response coming back from the port
    typedef struct packed {
        logic                   regResponse;
        logic [3:0]             destReg;
        logic [`PORT_WIDTH-1:0] data;
    } portRespT;

    // Register writeback to the core
    typedef struct packed {
        logic [3:0]             destReg;
        logic [`DATA_WIDTH-1:0] data;
    } writebackT;

endpackage

`default_nettype wire

// File: ioCmdResult.sv
// Response queue, load buffer, load alignment and writeback steering
`timescale 1ns/1ps
`default_nettype none

`include "ioCmd_params.svh"

module ioCmdResult (
    input  wire                   sys_clk,
    input  wire                   rstN,
    input  var ioCmdPkg::portRespT portResp,
    input  wire                   memResponse,
    input  wire                   portRespAck,
    output logic                  portRespReq,
    input  var ioCmdPkg::cpuCmdT  cmd,
    input  wire                   loadGo,
    output logic                  respPending,
    output ioCmdPkg::writebackT   writeback,
    output logic                  writebackAck,
    input  wire                   writebackReq
);

    // Queue entry carries the memory flag next to the port response
    typedef struct packed {
        logic               memResponse;
        ioCmdPkg::portRespT resp;
    } respEntryT;

    respEntryT              respIn;
    respEntryT              respHead;
    logic                   respInAck;
    logic                   headValid;
    logic                   headPop;
    logic [`PORT_WIDTH-1:0] loadBuffer;
    logic [`PORT_WIDTH-1:0] laneShifted;
    logic [`DATA_WIDTH-1:0] loadData;

    assign respIn.memResponse = memResponse;
    assign respIn.resp        = portResp;

    // Responses without either flag are not taken
    assign respInAck = portRespAck && (portResp.regResponse || memResponse);

    // Register responses wait for the core, memory responses drain at once
    assign respPending = headValid && respHead.resp.regResponse;
    assign headPop     = respHead.resp.regResponse ? writebackReq : respHead.memResponse;

    ioCmdFifo #(
        .payloadT(respEntryT)
    ) respQueue (
        .sys_clk(sys_clk),
        .rstN   (rstN),
        .inAck  (respInAck),
        .inReq  (portRespReq),
        .inData (respIn),
        .outAck (headValid),
        .outReq (headPop),
        .outData(respHead)
    );

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            loadBuffer <= '0;
        end else if (headValid && headPop) begin
            loadBuffer <= respHead.resp.data;
        end
    end

    // Move the addressed lanes down to bit 0, then zero-extend
    always_comb begin
        if (cmd.minorOp[1:0] == 2'd0) begin
            laneShifted = loadBuffer >> {cmd.addrOffset[1:0], 3'b000};
            loadData    = {{(`DATA_WIDTH - 8){1'b0}}, laneShifted[7:0]};
        end else begin
            laneShifted = loadBuffer >> {cmd.addrOffset[1], 4'b0000};
            loadData    = laneShifted[`DATA_WIDTH-1:0];
        end
    end

    // Pending register response owns the writeback port
    always_comb begin
        if (respPending) begin
            writebackAck      = 1'b1;
            writeback.destReg = respHead.resp.destReg;
            writeback.data    = respHead.resp.data[`DATA_WIDTH-1:0];
        end else begin
            writebackAck      = loadGo;
            writeback.destReg = cmd.destReg;
            writeback.data    = loadData;
        end
    end

endmodule

`default_nettype wire

// File: ioCmdTb.sv
// Testbench for the IO command controller with port responder, reference model and checks
`timescale 1ns/1ps
`default_nettype none

`include "ioCmd_params.svh"

module ioCmdTb;

    localparam int WAIT_LIMIT = 200;

    logic                   sys_clk;
    logic                   rstN;
    ioCmdPkg::cpuCmdT       cmd;
    logic                   cmdAck;
    logic                   cmdReq;
    ioCmdPkg::writebackT    writeback;
    logic                   writebackAck;
    logic                   writebackReq;
    ioCmdPkg::portCmdT      portCmd;
    logic                   portCmdAck;
    logic                   portCmdReq;
    ioCmdPkg::portRespT     portResp;
    logic                   memResponse;
    logic                   portRespAck;
    logic                   portRespReq;

    // Reference model
    logic [`PORT_WIDTH-1:0] shadowModel;
    logic [`PORT_WIDTH-1:0] bufferModel;
    ioCmdPkg::portCmdT      expPortCmds[$];
    ioCmdPkg::writebackT    expWritebacks[$];
    integer                 seed;
    integer                 portSeed;
    logic                   holdPort;

    ioCommandController DUT (.*);

    always #50 sys_clk = ~sys_clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic checkPortCmd(input ioCmdPkg::portCmdT got, input ioCmdPkg::portCmdT exp);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: port command rr=%0b reg=%h data=%h, %s",
                $time, got.responseRequested, got.destReg, got.data,
                $sformatf("expected rr=%0b reg=%h data=%h",
                    exp.responseRequested, exp.destReg, exp.data)));
        end
    endtask

    task automatic checkWriteback(input ioCmdPkg::writebackT got, input ioCmdPkg::writebackT exp);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: writeback reg=%h data=%h, %s",
                $time, got.destReg, got.data,
                $sformatf("expected reg=%h data=%h", exp.destReg, exp.data)));
        end
    endtask

    // Byte lanes touched by a command, from size and offset
    function automatic logic [`PORT_BYTES-1:0] lanesOf(input ioCmdPkg::cpuCmdT c);
        if (c.minorOp[1:0] == 2'd0) begin
            return 4'b0001 << c.addrOffset[1:0];
        end
        return c.addrOffset[1] ? 4'b1100 : 4'b0011;
    endfunction

    // Even lanes of a 16-bit store take the low byte, odd lanes the high byte
    function automatic logic [`PORT_WIDTH-1:0] mergeStore(input logic [`PORT_WIDTH-1:0] word,
                                                          input ioCmdPkg::cpuCmdT c);
        logic [`PORT_BYTES-1:0] lanes;
        lanes = lanesOf(c);
        for (int i = 0; i < `PORT_BYTES; i++) begin
            if (lanes[i]) begin
                if (c.minorOp[1:0] == 2'd0 || i % 2 == 0) begin
                    word[i*8 +: 8] = c.data[7:0];
                end else begin
                    word[i*8 +: 8] = c.data[15:8];
                end
            end
        end
        return word;
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] loadValue(input logic [`PORT_WIDTH-1:0] word,
                                                         input ioCmdPkg::cpuCmdT c);
        if (c.minorOp[1:0] == 2'd0) begin
            return {{(`DATA_WIDTH - 8){1'b0}}, word[c.addrOffset[1:0]*8 +: 8]};
        end
        return word[c.addrOffset[1]*16 +: 16];
    endfunction

    function automatic ioCmdPkg::cpuCmdT randomCmd(input ioCmdPkg::cmdClassT kind);
        ioCmdPkg::cpuCmdT c;
        c.minorOp[1:0] = 2'($random(seed) & 1);
        c.minorOp[2]   = (kind == ioCmdPkg::STORE);
        c.minorOp[3]   = (kind == ioCmdPkg::ATOMIC_LOAD);
        c.destReg      = 4'($random(seed));
        c.addrOffset   = `DATA_WIDTH'($random(seed));
        c.data         = `DATA_WIDTH'($random(seed));
        return c;
    endfunction

    // Waits for the accept while cmd is already offered, then moves the model
    task automatic completeCmd(input ioCmdPkg::cpuCmdT c);
        int                  waited;
        ioCmdPkg::portCmdT   pc;
        ioCmdPkg::writebackT wb;
        waited = 0;
        @(negedge sys_clk);
        while (!cmdReq) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                failRun("Timeout: the controller never accepted a command");
            end
            @(negedge sys_clk);
        end
        if (c.minorOp[2] || c.minorOp[3]) begin
            if (c.minorOp[2]) begin
                shadowModel = mergeStore(shadowModel, c);
            end
            pc.responseRequested = !c.minorOp[2];
            pc.destReg           = c.destReg;
            pc.data              = shadowModel;
            expPortCmds.push_back(pc);
        end else begin
            if (!writebackAck) begin
                failRun("A stale load was accepted without a writeback offer");
            end
            wb.destReg = c.destReg;
            wb.data    = loadValue(bufferModel, c);
            checkWriteback(writeback, wb);
        end
        @(posedge sys_clk);
        cmdAck <= 1'b0;
    endtask

    task automatic sendCmd(input ioCmdPkg::cpuCmdT c);
        @(posedge sys_clk);
        cmd    <= c;
        cmdAck <= 1'b1;
        completeCmd(c);
    endtask

    task automatic sendResp(input bit isReg, input bit isMem);
        int                     waited;
        logic [`PORT_WIDTH-1:0] data;
        logic [3:0]             dest;
        ioCmdPkg::writebackT    wb;
        waited = 0;
        data   = `PORT_WIDTH'($random(seed));
        dest   = 4'($random(seed));
        @(posedge sys_clk);
        portResp.regResponse <= isReg;
        portResp.destReg     <= dest;
        portResp.data        <= data;
        memResponse          <= isMem;
        portRespAck          <= 1'b1;
        @(negedge sys_clk);
        while (!portRespReq) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                failRun("Timeout: the response queue never took a response");
            end
            @(negedge sys_clk);
        end
        if (isReg) begin
            wb.destReg = dest;
            wb.data    = data[`DATA_WIDTH-1:0];
            expWritebacks.push_back(wb);
        end
        // Buffer holds the newest response once the queue has drained
        bufferModel = data;
        @(posedge sys_clk);
        portRespAck <= 1'b0;
    endtask

    task automatic drainWritebacks(input bit loadWaiting);
        int waited;
        while (expWritebacks.size() > 0) begin
            waited = 0;
            @(negedge sys_clk);
            while (!writebackAck) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    failRun("Timeout: a register response never reached the writeback port");
                end
                @(negedge sys_clk);
            end
            if (loadWaiting && cmdReq) begin
                failRun($sformatf("CHECK FAILED at %0t: stale load not held off", $time));
            end
            checkWriteback(writeback, expWritebacks.pop_front());
            @(posedge sys_clk);
        end
    endtask

    // Response queue filled and held, then released with an optional stale load waiting
    task automatic responseRound(input bit withLoad);
        ioCmdPkg::cpuCmdT c;
        int               kind;
        @(posedge sys_clk);
        writebackReq <= 1'b0;
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            // 0 memory, 1 register, 2 both flags
            kind = {$random(seed)} % 3;
            if ((i == 0 || withLoad) && kind == 0) begin
                kind = 1;
            end
            sendResp(kind != 0, kind != 1);
        end
        // Register response at the head blocks every pop, so the queue is full
        @(negedge sys_clk);
        if (portRespReq) begin
            failRun($sformatf("CHECK FAILED at %0t: full response queue still open", $time));
        end
        c = randomCmd(ioCmdPkg::LOAD);
        @(posedge sys_clk);
        writebackReq <= 1'b1;
        if (withLoad) begin
            cmd    <= c;
            cmdAck <= 1'b1;
        end
        drainWritebacks(withLoad);
        if (withLoad) begin
            completeCmd(c);
        end else begin
            // Memory responses behind the last register response pop on their own
            repeat (`QUEUE_DEPTH - 1) @(posedge sys_clk);
        end
        for (int i = 0; i < 4; i++) begin
            sendCmd(randomCmd(ioCmdPkg::LOAD));
        end
    endtask

    task automatic waitPortDrain();
        int waited;
        waited = 0;
        while (expPortCmds.size() > 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                failRun("Timeout: queued port commands never came out");
            end
            @(posedge sys_clk);
        end
    endtask

    // Port side: random readiness, stalled on request
    always @(posedge sys_clk) begin
        if (rstN) begin
            portCmdReq <= holdPort ? 1'b0 : 1'($random(portSeed));
        end
    end

    always @(negedge sys_clk) begin
        if (rstN && portCmdAck && portCmdReq) begin
            if (expPortCmds.size() == 0) begin
                failRun("A port command came out that was never queued");
            end else begin
                checkPortCmd(portCmd, expPortCmds.pop_front());
            end
        end
    end

    initial begin
        ioCmdPkg::cpuCmdT c;
        seed         = 32'h6d23;
        portSeed     = seed ^ 32'h0000_5a5a;
        sys_clk      = 1'b0;
        rstN         = 1'b0;
        cmd          = '0;
        cmdAck       = 1'b0;
        writebackReq = 1'b0;
        portCmdReq   = 1'b0;
        portResp     = '0;
        memResponse  = 1'b0;
        portRespAck  = 1'b0;
        shadowModel  = '0;
        bufferModel  = '0;
        holdPort     = 1'b0;
        repeat (5) @(posedge sys_clk);
        rstN <= 1'b1;

        // Quiet after reset
        repeat (8) begin
            @(negedge sys_clk);
            if (portCmdAck || writebackAck || cmdReq) begin
                failRun($sformatf("CHECK FAILED at %0t: handshake active after reset", $time));
            end
        end
        @(posedge sys_clk);
        writebackReq <= 1'b1;

        // Stores mixed with atomic loads
        for (int n = 0; n < 40; n++) begin
            if (($random(seed) & 3) == 0) begin
                sendCmd(randomCmd(ioCmdPkg::ATOMIC_LOAD));
            end else begin
                sendCmd(randomCmd(ioCmdPkg::STORE));
            end
        end
        waitPortDrain();

        // Memory responses, then stale loads at every size and offset
        for (int r = 0; r < 3; r++) begin
            sendResp(1'b0, 1'b1);
            for (int s = 0; s < 2; s++) begin
                for (int off = 0; off < `PORT_BYTES; off++) begin
                    c                 = randomCmd(ioCmdPkg::LOAD);
                    c.minorOp[1:0]    = 2'(s);
                    c.addrOffset[1:0] = 2'(off);
                    sendCmd(c);
                end
            end
        end

        for (int r = 0; r < 4; r++) begin
            responseRound(1'b1);
            responseRound(1'b0);
        end

        // Stalled port fills the command queue
        @(negedge sys_clk);
        holdPort = 1'b1;
        for (int n = 0; n < `QUEUE_DEPTH; n++) begin
            sendCmd(randomCmd(ioCmdPkg::STORE));
        end
        c = randomCmd(ioCmdPkg::STORE);
        @(posedge sys_clk);
        cmd    <= c;
        cmdAck <= 1'b1;
        repeat (6) begin
            @(negedge sys_clk);
            if (cmdReq || !portCmdAck) begin
                failRun($sformatf("CHECK FAILED at %0t: full command queue still open", $time));
            end
        end
        holdPort = 1'b0;
        completeCmd(c);
        for (int n = 0; n < 10; n++) begin
            sendCmd(randomCmd(n % 3 == 0 ? ioCmdPkg::ATOMIC_LOAD : ioCmdPkg::STORE));
        end
        waitPortDrain();

        repeat (5) @(posedge sys_clk);
        if (expPortCmds.size() == 0 && expWritebacks.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            failRun("Expected results were left over at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: ioCmd_params.svh
// Width and depth macros for the IO command controller
`ifndef IOCMD_PARAMS_SVH
`define IOCMD_PARAMS_SVH

// Core data and writeback word width
`define DATA_WIDTH 16

// External port word, in bytes and in bits
`define PORT_BYTES 4
`define PORT_WIDTH (`PORT_BYTES * 8)

// Entries in the command queue and in the response queue
`define QUEUE_DEPTH 4

`endif

// File: ioCommandController.sv
// Top level of the IO command controller joining decode, execute and result
`timescale 1ns/1ps
`default_nettype none

`include "ioCmd_params.svh"

module ioCommandController (
    input  wire                    sys_clk,
    input  wire                    rstN,

    // Core command
    input  var ioCmdPkg::cpuCmdT   cmd,
    input  wire                    cmdAck,
    output logic                   cmdReq,

    // Register writeback
    output ioCmdPkg::writebackT    writeback,
    output logic                   writebackAck,
    input  wire                    writebackReq,

    // Port command
    output ioCmdPkg::portCmdT      portCmd,
    output logic                   portCmdAck,
    input  wire                    portCmdReq,

    // Port response
    input  var ioCmdPkg::portRespT portResp,
    input  wire                    memResponse,
    input  wire                    portRespAck,
    output logic                   portRespReq
);

    ioCmdPkg::cmdClassT     cmdClass;
    wire [`PORT_BYTES-1:0]  laneMask;
    wire                    storeGo;
    wire                    queueGo;
    wire                    loadGo;
    wire                    queueReq;
    wire                    respPending;

    ioCmdDecode decode (
        .cmd         (cmd),
        .cmdAck      (cmdAck),
        .cmdReq      (cmdReq),
        .queueReq    (queueReq),
        .writebackReq(writebackReq),
        .respPending (respPending),
        .cmdClass    (cmdClass),
        .laneMask    (laneMask),
        .storeGo     (storeGo),
        .queueGo     (queueGo),
        .loadGo      (loadGo)
    );

    // Stores and atomic loads share the command queue
    ioCmdExecute execute (
        .sys_clk   (sys_clk),
        .rstN      (rstN),
        .cmd       (cmd),
        .cmdClass  (cmdClass),
        .laneMask  (laneMask),
        .queueGo   (storeGo | queueGo),
        .queueReq  (queueReq),
        .portCmd   (portCmd),
        .portCmdAck(portCmdAck),
        .portCmdReq(portCmdReq)
    );

    ioCmdResult result (
        .sys_clk     (sys_clk),
        .rstN        (rstN),
        .portResp    (portResp),
        .memResponse (memResponse),
        .portRespAck (portRespAck),
        .portRespReq (portRespReq),
        .cmd         (cmd),
        .loadGo      (loadGo),
        .respPending (respPending),
        .writeback   (writeback),
        .writebackAck(writebackAck),
        .writebackReq(writebackReq)
    );

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
ioCmdPkg.sv
ioCmdFifo.sv
ioCmdDecode.sv
ioCmdExecute.sv
ioCmdResult.sv
ioCommandController.sv
ioCmdTb.sv
